//--- list.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_array.sv
hw/cache_dpath.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
  verilator --binary --top-module cache_tb -f list.f -o cache_sim &&
  ./obj_dir/cache_sim | tee /dev/stderr | grep -F "Simulation passed" > /dev/null &&
  echo "run.sh: PASS" ||
  { echo "run.sh: FAIL"; exit 1; }

//--- tests/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam logic [31:0] SEED = 32'h78e6_20d9;
  // Worst access about 16 cycles (spill, refill, stalls), 208 accesses
  localparam int MAX_CYCLES = 4000;

  logic                 clk;
  logic                 reset;
  logic                 memreq_val, memreq_rdy;
  cache_pkg::req_type_e memreq_type;
  cache_pkg::addr_t     memreq_addr;
  cache_pkg::word_t     memreq_data;
  logic                 memresp_val, memresp_rdy;
  cache_pkg::req_type_e memresp_type;
  cache_pkg::word_t     memresp_data;
  logic                 cache_req_val, cache_req_rdy;
  cache_pkg::req_type_e cache_req_type;
  cache_pkg::addr_t     cache_req_addr;
  cache_pkg::word_t     cache_req_data;
  logic                 cache_resp_val, cache_resp_rdy;
  cache_pkg::word_t     cache_resp_data;

  logic        stall_on    = 1'b0;
  logic        mem_stall   = 1'b0;
  logic [31:0] rand_state  = SEED;
  logic [31:0] stall_state = ~SEED;   // Own stream for the stall process
  int          cycle_cnt   = 0;

  cache_pkg::word_t shadow [cache_pkg::addr_t];   // Only written words

  cache_top UUT (.*);

  mem_model mem (
    .clk, .reset, .stall (mem_stall),
    .req_val (cache_req_val), .req_rdy (cache_req_rdy), .req_type (cache_req_type),
    .req_addr (cache_req_addr), .req_data (cache_req_data),
    .resp_val (cache_resp_val), .resp_rdy (cache_resp_rdy), .resp_data (cache_resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (stall_on) begin
      stall_state = lcg_next(stall_state);
      mem_stall   = (stall_state[31:30] == 2'b00);   // About one cycle in four
    end else begin
      mem_stall = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: test run exceeded %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory content rule, overridden by words already written
  function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return {16'hC0DE, a};
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_type(input string name, input cache_pkg::req_type_e exp,
                            input cache_pkg::req_type_e act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
      $display("Simulation failed");
      $fatal(1, "Type mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "Handshake mismatch");
    end
  endtask

  // Offer until accepted, then collect the response at the edge it is taken
  task automatic access(input cache_pkg::req_type_e t, input cache_pkg::addr_t a,
                        input cache_pkg::word_t d, output cache_pkg::word_t rdata,
                        output cache_pkg::req_type_e rtype);
    @(negedge clk);
    memreq_val  = 1'b1;
    memreq_type = t;
    memreq_addr = a;
    memreq_data = d;
    do @(posedge clk); while (!memreq_rdy);
    @(negedge clk);
    memreq_val = 1'b0;
    do @(posedge clk); while (!(memresp_val && memresp_rdy));
    rdata = memresp_data;
    rtype = memresp_type;
  endtask

  task automatic read_check(input cache_pkg::addr_t a);
    cache_pkg::word_t     data;
    cache_pkg::req_type_e rtype;
    access(cache_pkg::cache_read, a, '0, data, rtype);
    check_type("memresp_type", cache_pkg::cache_read, rtype);
    check_word("memresp_data", expected_word(a), data);
  endtask

  task automatic write_check(input cache_pkg::addr_t a, input cache_pkg::word_t d);
    cache_pkg::word_t     data;
    cache_pkg::req_type_e rtype;
    access(cache_pkg::cache_write, a, d, data, rtype);
    check_type("memresp_type", cache_pkg::cache_write, rtype);
    shadow[a] = d;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_clean_miss();
    @(posedge clk);
    check_flag("memreq_rdy", 1'b1, memreq_rdy);   // Idle after reset
    check_flag("memresp_val", 1'b0, memresp_val);
    check_flag("cache_req_val", 1'b0, cache_req_val);
    check_flag("cache_resp_rdy", 1'b0, cache_resp_rdy);   // Only raised in refill
    read_check(16'h0040);   // Miss, refill of a clean line
    read_check(16'h0042);   // Same line, hit
  endtask

  task automatic test_write_hit();
    write_check(16'h0041, 32'hdead_beef);
    read_check(16'h0041);
  endtask

  task automatic test_dirty_evict();
    write_check(16'h0041, 32'h1234_5678);
    read_check(16'h0061);   // Same index, other tag, victim spilled
    read_check(16'h0041);   // Only right if the spill reached memory
  endtask

  task automatic test_resp_backpressure();
    cache_pkg::word_t     held_data;
    cache_pkg::req_type_e held_type;
    @(negedge clk);
    memresp_rdy = 1'b0;
    @(negedge clk);
    memreq_val  = 1'b1;
    memreq_type = cache_pkg::cache_read;
    memreq_addr = 16'h0042;
    do @(posedge clk); while (!memreq_rdy);
    @(negedge clk);
    memreq_val = 1'b0;
    do @(posedge clk); while (!memresp_val);
    held_data = memresp_data;
    held_type = memresp_type;
    check_word("memresp_data", expected_word(16'h0042), held_data);
    check_type("memresp_type", cache_pkg::cache_read, held_type);
    repeat (4) begin
      check_flag("memreq_rdy", 1'b0, memreq_rdy);   // Slot still full
      @(posedge clk);
      check_flag("memresp_val", 1'b1, memresp_val);
      check_word("memresp_data", held_data, memresp_data);
      check_type("memresp_type", held_type, memresp_type);
    end
    @(negedge clk);
    memresp_rdy = 1'b1;
    @(posedge clk);
    check_flag("memreq_rdy", 1'b1, memreq_rdy);   // Frees as it is taken
  endtask

  task automatic test_random_mix();
    cache_pkg::addr_t a;
    cache_pkg::word_t d;
    logic             is_wr;
    stall_on = 1'b1;
    for (int n = 0; n < 200; n++) begin
      rand_state = lcg_next(rand_state);
      is_wr      = rand_state[31];
      a          = {10'h020, rand_state[21:16]};   // 64 words, two tags per index
      rand_state = lcg_next(rand_state);
      d          = rand_state;
      if (is_wr) begin
        write_check(a, d);
      end else begin
        read_check(a);
      end
    end
    stall_on = 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    reset       = 1'b1;
    memreq_val  = 1'b0;
    memreq_type = cache_pkg::cache_read;
    memreq_addr = '0;
    memreq_data = '0;
    memresp_rdy = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    test_clean_miss();
    test_write_hit();
    test_dirty_evict();
    test_resp_backpressure();
    test_random_mix();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

// Word memory behind the cache, word at a starts as {16'hC0DE, a}
module mem_model (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,       // Forces req_rdy low this cycle

  // Request from the cache
  input  logic                 req_val,
  output logic                 req_rdy,
  input  cache_pkg::req_type_e req_type,
  input  cache_pkg::addr_t     req_addr,
  input  cache_pkg::word_t     req_data,

  // Read response to the cache
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output cache_pkg::word_t     resp_data
);

  localparam int DEPTH = 1 << `CACHE_ADDR_W;

  cache_pkg::word_t mem [DEPTH];
  logic             req_go;
  logic             rd_go;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[16'(i)] = {16'hC0DE, 16'(i)};   // Whole address in the low half
    end
  end

  // ------------------------------
  // Handshakes
  // ------------------------------

  // Response slot empty or draining on this edge
  assign req_rdy = !stall && (!resp_val || resp_rdy);
  assign req_go  = req_val && req_rdy;
  assign rd_go   = req_go && (req_type == cache_pkg::cache_read);

  always_ff @(posedge clk) begin
    if (req_go && req_type == cache_pkg::cache_write) begin
      mem[req_addr] <= req_data;   // Spill word, no response
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (rd_go) begin
      resp_val <= 1'b1;   // Answer one cycle after the request
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      resp_data <= mem[req_addr];   // Held until taken
    end
  end

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                  clk,
  input  logic                  reset,

  // Processor request
  input  logic                  memreq_val,
  output logic                  memreq_rdy,
  input  cache_pkg::req_type_e  memreq_type,
  input  cache_pkg::addr_t      memreq_addr,
  input  cache_pkg::word_t      memreq_data,

  // Processor response
  output logic                  memresp_val,
  input  logic                  memresp_rdy,
  output cache_pkg::req_type_e  memresp_type,
  output cache_pkg::word_t      memresp_data,

  // Memory request
  output logic                  cache_req_val,
  input  logic                  cache_req_rdy,
  output cache_pkg::req_type_e  cache_req_type,
  output cache_pkg::addr_t      cache_req_addr,
  output cache_pkg::word_t      cache_req_data,

  // Memory response
  input  logic                  cache_resp_val,
  output logic                  cache_resp_rdy,
  input  cache_pkg::word_t      cache_resp_data
);

  // ------------------------------
  // Control and status wires
  // ------------------------------

  logic req_en, tag_wen, data_wen, refill_wen, set_dirty;
  logic spill_one_word_done, refill_one_word_req_sent, refill_one_word_resp_received;
  logic spill_or_refill_sel;

  logic                 req_held, tarray_match, current_dirty;
  logic                 spill_done, refill_req_done, refill_resp_done;
  cache_pkg::req_type_e req_type;

  cache_ctrl ctrl (
    .clk, .reset,
    .memreq_rdy, .memresp_val, .memresp_rdy,
    .cache_req_val, .cache_req_rdy, .cache_req_type,
    .cache_resp_val, .cache_resp_rdy,
    .req_en, .tag_wen, .data_wen, .refill_wen, .set_dirty,
    .spill_one_word_done, .refill_one_word_req_sent, .refill_one_word_resp_received,
    .spill_or_refill_sel,
    .req_held, .req_type, .tarray_match, .current_dirty,
    .spill_done, .refill_req_done, .refill_resp_done
  );

  cache_dpath dpath (
    .clk, .reset,
    .memreq_val, .memreq_addr, .memreq_data, .memreq_type,
    .memresp_data, .memresp_type,
    .cache_req_addr, .cache_req_data, .cache_resp_data,
    .req_en, .tag_wen, .data_wen, .refill_wen, .set_dirty,
    .spill_one_word_done, .refill_one_word_req_sent, .refill_one_word_resp_received,
    .spill_or_refill_sel,
    .req_held, .req_type, .tarray_match, .current_dirty,
    .spill_done, .refill_req_done, .refill_resp_done
  );

endmodule

`default_nettype wire

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                  clk,
  input  logic                  reset,

  // Processor side handshakes
  output logic                  memreq_rdy,
  output logic                  memresp_val,
  input  logic                  memresp_rdy,

  // Memory side handshakes
  output logic                  cache_req_val,
  input  logic                  cache_req_rdy,
  output cache_pkg::req_type_e  cache_req_type,
  input  logic                  cache_resp_val,
  output logic                  cache_resp_rdy,

  // Control to cache_dpath
  output logic                  req_en,
  output logic                  tag_wen,
  output logic                  data_wen,
  output logic                  refill_wen,
  output logic                  set_dirty,
  output logic                  spill_one_word_done,
  output logic                  refill_one_word_req_sent,
  output logic                  refill_one_word_resp_received,
  output logic                  spill_or_refill_sel,

  // Status from cache_dpath
  input  logic                  req_held,
  input  cache_pkg::req_type_e  req_type,
  input  logic                  tarray_match,
  input  logic                  current_dirty,
  input  logic                  spill_done,
  input  logic                  refill_req_done,
  input  logic                  refill_resp_done
);

  cache_pkg::ctrl_state_e state_reg;
  cache_pkg::ctrl_state_e state_next;

  logic in_pipe;
  logic in_spill;
  logic in_refill;
  logic resp_go;        // Processor takes the response
  logic refill_sent;    // All refill reads are out

  assign in_pipe   = (state_reg == cache_pkg::st_pipe);
  assign in_spill  = (state_reg == cache_pkg::st_spill);
  assign in_refill = (state_reg == cache_pkg::st_refill);

  // ------------------------------
  // Processor side
  // ------------------------------

  // Hit answer, only from PIPE
  assign memresp_val = req_held & in_pipe & tarray_match;
  assign resp_go     = memresp_val & memresp_rdy;

  // Free slot, or slot empties on this edge
  assign memreq_rdy = !req_held || resp_go;
  assign req_en     = memreq_rdy;   // Register samples whatever is offered

  // Write hit commits when its response goes out
  assign data_wen  = resp_go && (req_type == cache_pkg::cache_write);
  assign set_dirty = data_wen;

  // ------------------------------
  // Memory side
  // ------------------------------

  // Stop requesting once the last refill read is out
  assign cache_req_val  = in_spill | (in_refill & !refill_sent);
  assign cache_req_type = in_spill ? cache_pkg::cache_write : cache_pkg::cache_read;
  assign cache_resp_rdy = in_refill;   // Spill writes get no response

  assign spill_or_refill_sel = in_refill;   // Address source in dpath

  // Per word strobes
  assign spill_one_word_done           = in_spill & cache_req_val & cache_req_rdy;
  assign refill_one_word_req_sent      = in_refill & cache_req_val & cache_req_rdy;
  assign refill_one_word_resp_received = in_refill & cache_resp_val & cache_resp_rdy;

  assign refill_wen = refill_one_word_resp_received;
  // Tag goes in with the last word
  assign tag_wen    = refill_one_word_resp_received & refill_resp_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      refill_sent <= 1'b0;
    end else if (refill_one_word_req_sent && refill_req_done) begin
      refill_sent <= 1'b1;
    end else if (tag_wen) begin
      refill_sent <= 1'b0;   // Ready for the next miss
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= cache_pkg::st_pipe;
    end else begin
      state_reg <= state_next;
    end
  end

  always_comb begin
    state_next = state_reg;   // Hold by default
    case (state_reg)
      cache_pkg::st_pipe: begin
        if (req_held && !tarray_match) begin
          // Dirty victim goes out first
          state_next = current_dirty ? cache_pkg::st_spill : cache_pkg::st_refill;
        end
      end
      cache_pkg::st_spill: begin
        if (spill_one_word_done && spill_done) begin
          state_next = cache_pkg::st_refill;
        end
      end
      cache_pkg::st_refill: begin
        if (tag_wen) begin
          state_next = cache_pkg::st_pipe;   // Held request now hits
        end
      end
      default: state_next = cache_pkg::st_pipe;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cache_dpath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_dpath (
  input  logic                  clk,
  input  logic                  reset,

  // Processor side payload
  input  logic                  memreq_val,
  input  cache_pkg::addr_t      memreq_addr,
  input  cache_pkg::word_t      memreq_data,
  input  cache_pkg::req_type_e  memreq_type,
  output cache_pkg::word_t      memresp_data,
  output cache_pkg::req_type_e  memresp_type,

  // Memory side payload
  output cache_pkg::addr_t      cache_req_addr,
  output cache_pkg::word_t      cache_req_data,
  input  cache_pkg::word_t      cache_resp_data,

  // Control from cache_ctrl
  input  logic                  req_en,
  input  logic                  tag_wen,
  input  logic                  data_wen,
  input  logic                  refill_wen,
  input  logic                  set_dirty,
  input  logic                  spill_one_word_done,
  input  logic                  refill_one_word_req_sent,
  input  logic                  refill_one_word_resp_received,
  input  logic                  spill_or_refill_sel,

  // Status to cache_ctrl
  output logic                  req_held,
  output cache_pkg::req_type_e  req_type,
  output logic                  tarray_match,
  output logic                  current_dirty,
  output logic                  spill_done,
  output logic                  refill_req_done,
  output logic                  refill_resp_done
);

  localparam int DATA_DEPTH = `CACHE_NUM_LINES * `CACHE_LINE_WORDS;

  // ------------------------------
  // Request register
  // ------------------------------

  cache_pkg::addr_t req_addr;
  cache_pkg::word_t req_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_held <= 1'b0;
    end else if (req_en) begin
      req_held <= memreq_val;   // Empty slot when nothing offered
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin   // Payload only, no reset
      req_addr <= memreq_addr;
      req_data <= memreq_data;
      req_type <= memreq_type;
    end
  end

  // Address split
  cache_pkg::tag_t    req_tag;
  cache_pkg::index_t  req_index;
  cache_pkg::offset_t req_offset;

  assign req_tag    = req_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign req_index  = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign req_offset = req_addr[`CACHE_OFFSET_W-1:0];

  // ------------------------------
  // Tags and valid bits
  // ------------------------------

  logic [`CACHE_NUM_LINES-1:0] valid_vec;   // Reset here, array has no reset
  cache_pkg::tag_entry_t       tag_rd;
  cache_pkg::tag_entry_t       tag_wdata;
  logic                        line_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_vec <= '0;
    end else if (tag_wen) begin
      valid_vec[req_index] <= 1'b1;
    end
  end

  // Refill installs clean, write hit rewrites same tag as dirty
  assign tag_wdata = '{valid: 1'b1, dirty: set_dirty, tag: req_tag};

  cache_array #(
    .DEPTH   (`CACHE_NUM_LINES),
    .entry_t (cache_pkg::tag_entry_t)
  ) tag_array (
    .clk   (clk),
    .wen   (tag_wen | set_dirty),
    .waddr (req_index),
    .wdata (tag_wdata),
    .raddr (req_index),
    .rdata (tag_rd)
  );

  assign line_valid    = valid_vec[req_index] & tag_rd.valid;
  assign tarray_match  = line_valid && (tag_rd.tag == req_tag);
  assign current_dirty = line_valid & tag_rd.dirty;   // Victim needs a spill

  // ------------------------------
  // Word counters
  // ------------------------------

  cache_pkg::offset_t spill_cnt;
  cache_pkg::offset_t refill_req_cnt;
  cache_pkg::offset_t refill_resp_cnt;

  // Each wraps to zero after the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      spill_cnt       <= '0;
      refill_req_cnt  <= '0;
      refill_resp_cnt <= '0;
    end else begin
      if (spill_one_word_done)           spill_cnt       <= spill_cnt + 1'b1;
      if (refill_one_word_req_sent)      refill_req_cnt  <= refill_req_cnt + 1'b1;
      if (refill_one_word_resp_received) refill_resp_cnt <= refill_resp_cnt + 1'b1;
    end
  end

  assign spill_done       = (spill_cnt == `CACHE_OFFSET_W'(`CACHE_LINE_WORDS - 1));
  assign refill_req_done  = (refill_req_cnt == `CACHE_OFFSET_W'(`CACHE_LINE_WORDS - 1));
  assign refill_resp_done = (refill_resp_cnt == `CACHE_OFFSET_W'(`CACHE_LINE_WORDS - 1));

  // ------------------------------
  // Data array
  // ------------------------------

  logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] data_raddr;
  logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] data_waddr;
  cache_pkg::word_t                          data_wdata;
  cache_pkg::word_t                          data_rd;

  // No match means a miss or a spill in progress, read the victim word
  assign data_raddr = tarray_match ? {req_index, req_offset} : {req_index, spill_cnt};

  // Refill word from memory, otherwise the write hit word
  assign data_waddr = refill_wen ? {req_index, refill_resp_cnt} : {req_index, req_offset};
  assign data_wdata = refill_wen ? cache_resp_data : req_data;

  cache_array #(
    .DEPTH   (DATA_DEPTH),
    .entry_t (cache_pkg::word_t)
  ) data_array (
    .clk   (clk),
    .wen   (data_wen | refill_wen),
    .waddr (data_waddr),
    .wdata (data_wdata),
    .raddr (data_raddr),
    .rdata (data_rd)
  );

  // ------------------------------
  // Port payloads
  // ------------------------------

  assign memresp_data = data_rd;
  assign memresp_type = req_type;   // Echo of the held request

  // Refill fetches the request's line, spill writes back the victim's line
  assign cache_req_addr = spill_or_refill_sel ? {req_tag, req_index, refill_req_cnt}
                                              : {tag_rd.tag, req_index, spill_cnt};
  assign cache_req_data = data_rd;   // Only meaningful for spill writes

endmodule

`default_nettype wire

//--- hw/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

// Register file storage, one write port and one async read port
module cache_array #(
  parameter int  DEPTH   = 8,
  parameter type entry_t = logic
) (
  input  logic                     clk,
  input  logic                     wen,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  entry_t                   wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output entry_t                   rdata
);

  // ------------------------------
  // Storage
  // ------------------------------

  entry_t mem [DEPTH];   // Contents unknown until written

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;   // Write lands on the edge
    end
  end

  // ------------------------------
  // Read side
  // ------------------------------

  // Combinational, so a hit answers in the cycle after acceptance
  assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  // ------------------------------
  // Data and address
  // ------------------------------
  typedef logic [`CACHE_WORD_W-1:0]   word_t;
  typedef logic [`CACHE_ADDR_W-1:0]   addr_t;

  typedef logic [`CACHE_TAG_W-1:0]    tag_t;
  typedef logic [`CACHE_INDEX_W-1:0]  index_t;
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

  // Same encoding on processor and memory ports
  typedef enum logic {
    cache_read  = 1'b0,
    cache_write = 1'b1
  } req_type_e;

  // One tag array slot
  typedef struct packed {
    logic valid;
    logic dirty;   // Line differs from memory
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    st_pipe,    // Hits served here
    st_spill,   // Dirty victim going out
    st_refill   // New line coming in
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ------------------------------
// Cache geometry
// ------------------------------

`define CACHE_WORD_W      32   // Data word width
`define CACHE_ADDR_W      16   // Word address, not byte address

`define CACHE_NUM_LINES   8    // Direct mapped, one way
`define CACHE_LINE_WORDS  4    // Words per line

// Address fields, tag | index | offset from high to low
`define CACHE_INDEX_W     3
`define CACHE_OFFSET_W    2
`define CACHE_TAG_W       11   // ADDR_W - INDEX_W - OFFSET_W

`endif
